//--- logic/neuro_cfg.svh
`ifndef NEURO_CFG_SVH
`define NEURO_CFG_SVH

// neuron and axon addressing
`define NEURON_CNT_W 6
`define NEURON_CNT (1 << `NEURON_CNT_W)
`define AXON_CNT_W 6
`define AXON_CNT (1 << `AXON_CNT_W)

// parameter values and learning window
`define DSIZE 16
`define STDP_WIN_W 8

// noc flit: header, vc, payload
`define HDR_W 2
`define PAYLOAD_W 32
`define FLIT_W 38

// readback word, wide enough for a zero-extended config word
`define RD_DATA_W 48

// timestep length in neuron_clk cycles
`define TIMESTEP_CYCLES 64

`endif

//--- logic/noc_pkg.sv
`include "neuro_cfg.svh"

package noc_pkg;

	// header bits at the top of every flit
	typedef enum logic [`HDR_W-1:0]
	{
		HDR_BODY   = 2'b00,
		HDR_TAIL   = 2'b01,
		HDR_HEAD   = 2'b10,
		HDR_SINGLE = 2'b11
	} flit_hdr_e;

	// payload seen as a neuron parameter write
	typedef struct packed
	{
		logic [3:0] pkt_type;
		logic [1:0] rsvd_hi;
		logic [`NEURON_CNT_W-1:0] neuron_id;
		logic [1:0] param_sel;
		logic [1:0] rsvd_lo;
		logic [`DSIZE-1:0] value;
	} param_flit_s;

	// payload seen as a spike
	typedef struct packed
	{
		logic [3:0] pkt_type;
		logic [9:0] rsvd_hi;
		logic [`AXON_CNT_W-1:0] axon_id;
		logic [11:0] rsvd_lo;
	} spike_flit_s;

	typedef union packed
	{
		param_flit_s param;
		spike_flit_s spike;
	} flit_payload_u;

endpackage

//--- logic/neuro_pkg.sv
`include "neuro_cfg.svh"

package neuro_pkg;

	// packet types handled by this core
	typedef enum logic [3:0]
	{
		PKT_SPIKE     = 4'd0,
		PKT_BIAS      = 4'd1,
		PKT_THRESHOLD = 4'd2,
		PKT_POTENTIAL = 4'd3,
		PKT_CONFIG_A  = 4'd6
	} pkt_type_e;

	// field select inside a config-A packet
	typedef enum logic [1:0]
	{
		SEL_LTP    = 2'd0,
		SEL_LTD    = 2'd1,
		SEL_WINDOW = 2'd2
	} param_sel_e;

	// learning config word, one per neuron
	typedef struct packed
	{
		logic [`DSIZE-1:0] ltp_rate;
		logic [`DSIZE-1:0] ltd_rate;
		logic [`STDP_WIN_W-1:0] stdp_window;
	} config_a_s;

	// readback selector
	typedef enum logic [1:0]
	{
		RD_BIAS      = 2'd0,
		RD_THRESHOLD = 2'd1,
		RD_POTENTIAL = 2'd2,
		RD_CONFIG    = 2'd3
	} mem_sel_e;

endpackage

//--- logic/decoder_fsm.sv
`timescale 1ns/1ps

module decoder_fsm
(
	input  logic                  neuron_clk,
	input  logic                  neuron_rst,
	input  logic                  flit_valid_i,
	input  noc_pkg::flit_hdr_e    flit_hdr_i,
	input  neuro_pkg::pkt_type_e  pkt_type_i,
	output logic                  flit_ready_o,
	output logic                  load_head_o,
	output logic                  load_field_o,
	output logic                  wr_status_o,
	output logic                  wr_config_o,
	output logic                  set_spike_o
);

	typedef enum logic [1:0]
	{
		ST_IDLE,
		ST_BUFFER,
		ST_WRITE
	} state_e;

	state_e state_q;
	state_e state_d;
	logic   flit_hs;

	assign flit_ready_o = (state_q != ST_WRITE);
	assign flit_hs = flit_valid_i & flit_ready_o;

	always_ff @(posedge neuron_clk or negedge neuron_rst)
	begin
		if (!neuron_rst)
			state_q <= ST_IDLE;
		else
			state_q <= state_d;
	end

	// next state and flit loads
	always_comb
	begin
		state_d = state_q;
		load_head_o = 1'b0;
		load_field_o = 1'b0;
		case (state_q)
			ST_IDLE, ST_BUFFER:
			begin
				if (flit_hs)
				begin
					case (flit_hdr_i)
						noc_pkg::HDR_HEAD:
						begin
							load_head_o = 1'b1;
							load_field_o = 1'b1;
							state_d = ST_BUFFER;
						end
						noc_pkg::HDR_SINGLE:
						begin
							load_head_o = 1'b1;
							load_field_o = 1'b1;
							state_d = ST_WRITE;
						end
						noc_pkg::HDR_BODY:
							load_field_o = (state_q == ST_BUFFER);
						noc_pkg::HDR_TAIL:
						begin
							// stray tail outside a packet is dropped
							if (state_q == ST_BUFFER)
							begin
								load_field_o = 1'b1;
								state_d = ST_WRITE;
							end
						end
						default:
							state_d = state_q;
					endcase
				end
			end
			ST_WRITE:
				state_d = ST_IDLE;
			default:
				state_d = ST_IDLE;
		endcase
	end

	// one strobe in write, picked by the latched type
	always_comb
	begin
		wr_status_o = 1'b0;
		wr_config_o = 1'b0;
		set_spike_o = 1'b0;
		if (state_q == ST_WRITE)
		begin
			case (pkt_type_i)
				neuro_pkg::PKT_SPIKE:
					set_spike_o = 1'b1;
				neuro_pkg::PKT_BIAS, neuro_pkg::PKT_THRESHOLD, neuro_pkg::PKT_POTENTIAL:
					wr_status_o = 1'b1;
				neuro_pkg::PKT_CONFIG_A:
					wr_config_o = 1'b1;
				default:
					wr_status_o = 1'b0;
			endcase
		end
	end

endmodule

//--- logic/packet_assembler.sv
`timescale 1ns/1ps
`include "neuro_cfg.svh"

module packet_assembler
(
	input  logic                         neuron_clk,
	input  logic                         neuron_rst,
	input  noc_pkg::flit_payload_u       payload_i,
	input  logic                         load_head_i,
	input  logic                         load_field_i,
	output neuro_pkg::pkt_type_e         pkt_type_o,
	output logic [`NEURON_CNT_W-1:0]     neuron_id_o,
	output logic [`AXON_CNT_W-1:0]       axon_id_o,
	output logic [`DSIZE-1:0]            status_value_o,
	output neuro_pkg::config_a_s         config_word_o
);

	neuro_pkg::pkt_type_e  pkt_type_q;
	neuro_pkg::pkt_type_e  cur_type;
	neuro_pkg::param_sel_e field_sel;
	logic [`NEURON_CNT_W-1:0] neuron_id_q;
	logic [`AXON_CNT_W-1:0]   axon_id_q;
	logic [`DSIZE-1:0]        value_q;
	neuro_pkg::config_a_s     config_q;
	logic                     is_status;

	// the head flit carries the type for itself
	assign cur_type = load_head_i ? neuro_pkg::pkt_type_e'(payload_i.param.pkt_type)
		: pkt_type_q;
	assign field_sel = neuro_pkg::param_sel_e'(payload_i.param.param_sel);
	assign is_status = (cur_type == neuro_pkg::PKT_BIAS) ||
		(cur_type == neuro_pkg::PKT_THRESHOLD) ||
		(cur_type == neuro_pkg::PKT_POTENTIAL);

	// type and ids from the head flit
	always_ff @(posedge neuron_clk or negedge neuron_rst)
	begin
		if (!neuron_rst)
		begin
			pkt_type_q <= neuro_pkg::PKT_SPIKE;
			neuron_id_q <= '0;
			axon_id_q <= '0;
		end
		else if (load_head_i)
		begin
			pkt_type_q <= cur_type;
			if (cur_type == neuro_pkg::PKT_SPIKE)
				axon_id_q <= payload_i.spike.axon_id;
			else
				neuron_id_q <= payload_i.param.neuron_id;
		end
	end

	// value fields, later flits overwrite
	always_ff @(posedge neuron_clk or negedge neuron_rst)
	begin
		if (!neuron_rst)
		begin
			value_q <= '0;
			config_q <= '0;
		end
		else
		begin
			if (load_head_i)
				config_q <= '0;
			if (load_field_i && is_status)
				value_q <= payload_i.param.value;
			if (load_field_i && (cur_type == neuro_pkg::PKT_CONFIG_A))
			begin
				case (field_sel)
					neuro_pkg::SEL_LTP:
						config_q.ltp_rate <= payload_i.param.value;
					neuro_pkg::SEL_LTD:
						config_q.ltd_rate <= payload_i.param.value;
					neuro_pkg::SEL_WINDOW:
						config_q.stdp_window <= payload_i.param.value[`STDP_WIN_W-1:0];
					default:
						;
				endcase
			end
		end
	end

	assign pkt_type_o = pkt_type_q;
	assign neuron_id_o = neuron_id_q;
	assign axon_id_o = axon_id_q;
	assign status_value_o = value_q;
	assign config_word_o = config_q;

endmodule

//--- logic/spike_buffer.sv
`timescale 1ns/1ps
`include "neuro_cfg.svh"

module spike_buffer
(
	input  logic                    neuron_clk,
	input  logic                    neuron_rst,
	input  logic                    set_spike_i,
	input  logic [`AXON_CNT_W-1:0]  axon_id_i,
	input  logic                    tick_i,
	output logic [`AXON_CNT-1:0]    spike_vec_o,
	output logic                    spike_vec_valid_o
);

	logic [`AXON_CNT-1:0] spikes_q;

	always_ff @(posedge neuron_clk or negedge neuron_rst)
	begin
		if (!neuron_rst)
		begin
			spikes_q <= '0;
			spike_vec_o <= '0;
			spike_vec_valid_o <= 1'b0;
		end
		else
		begin
			spike_vec_valid_o <= tick_i;
			if (tick_i)
			begin
				spike_vec_o <= spikes_q;
				spikes_q <= '0;
			end
			// a set on tick goes to the next timestep
			if (set_spike_i)
				spikes_q[axon_id_i] <= 1'b1;
		end
	end

endmodule

//--- logic/timestep_timer.sv
`timescale 1ns/1ps
`include "neuro_cfg.svh"

module timestep_timer
(
	input  logic neuron_clk,
	input  logic neuron_rst,
	output logic tick_o
);

	localparam int CNT_W = $clog2(`TIMESTEP_CYCLES);

	logic [CNT_W-1:0] cycle_cnt;

	assign tick_o = (cycle_cnt == CNT_W'(`TIMESTEP_CYCLES - 1));

	// wraps at the end of each timestep
	always_ff @(posedge neuron_clk or negedge neuron_rst)
	begin
		if (!neuron_rst)
			cycle_cnt <= '0;
		else if (tick_o)
			cycle_cnt <= '0;
		else
			cycle_cnt <= cycle_cnt + 1'b1;
	end

endmodule

//--- logic/neuron_state_mem.sv
`timescale 1ns/1ps
`include "neuro_cfg.svh"

module neuron_state_mem
(
	input  logic                      neuron_clk,
	input  logic                      neuron_rst,
	input  logic                      wr_status_i,
	input  logic                      wr_config_i,
	input  neuro_pkg::pkt_type_e      pkt_type_i,
	input  logic [`NEURON_CNT_W-1:0]  neuron_id_i,
	input  logic [`DSIZE-1:0]         status_value_i,
	input  neuro_pkg::config_a_s      config_word_i,
	input  logic [`NEURON_CNT_W-1:0]  rd_neuron_i,
	input  neuro_pkg::mem_sel_e       rd_sel_i,
	output logic [`RD_DATA_W-1:0]     rd_data_o
);

	logic [`DSIZE-1:0]    bias_mem [`NEURON_CNT];
	logic [`DSIZE-1:0]    threshold_mem [`NEURON_CNT];
	logic [`DSIZE-1:0]    potential_mem [`NEURON_CNT];
	neuro_pkg::config_a_s config_mem [`NEURON_CNT];

	always_ff @(posedge neuron_clk or negedge neuron_rst)
	begin
		if (!neuron_rst)
		begin
			bias_mem <= '{default: '0};
			threshold_mem <= '{default: '0};
			potential_mem <= '{default: '0};
			config_mem <= '{default: '0};
		end
		else
		begin
			// status array chosen by packet type
			if (wr_status_i)
			begin
				case (pkt_type_i)
					neuro_pkg::PKT_BIAS:
						bias_mem[neuron_id_i] <= status_value_i;
					neuro_pkg::PKT_THRESHOLD:
						threshold_mem[neuron_id_i] <= status_value_i;
					neuro_pkg::PKT_POTENTIAL:
						potential_mem[neuron_id_i] <= status_value_i;
					default:
						bias_mem[neuron_id_i] <= bias_mem[neuron_id_i];
				endcase
			end
			if (wr_config_i)
				config_mem[neuron_id_i] <= config_word_i;
		end
	end

	// zero-extended combinational readback
	always_comb
	begin
		rd_data_o = '0;
		case (rd_sel_i)
			neuro_pkg::RD_BIAS:
				rd_data_o[`DSIZE-1:0] = bias_mem[rd_neuron_i];
			neuro_pkg::RD_THRESHOLD:
				rd_data_o[`DSIZE-1:0] = threshold_mem[rd_neuron_i];
			neuro_pkg::RD_POTENTIAL:
				rd_data_o[`DSIZE-1:0] = potential_mem[rd_neuron_i];
			default:
				rd_data_o[$bits(neuro_pkg::config_a_s)-1:0] = config_mem[rd_neuron_i];
		endcase
	end

endmodule

//--- logic/neuro_core_rx.sv
`timescale 1ns/1ps
`include "neuro_cfg.svh"

module neuro_core_rx
(
	input  logic                      neuron_clk,
	input  logic                      neuron_rst,
	input  logic [`FLIT_W-1:0]        flit_i,
	input  logic                      flit_valid_i,
	output logic                      flit_ready_o,
	input  logic [`NEURON_CNT_W-1:0]  rd_neuron_i,
	input  neuro_pkg::mem_sel_e       rd_sel_i,
	output logic [`RD_DATA_W-1:0]     rd_data_o,
	output logic [`AXON_CNT-1:0]      spike_vec_o,
	output logic                      spike_vec_valid_o
);

	noc_pkg::flit_hdr_e       flit_hdr;
	noc_pkg::flit_payload_u   flit_payload;
	neuro_pkg::pkt_type_e     pkt_type;
	neuro_pkg::config_a_s     config_word;
	logic [`NEURON_CNT_W-1:0] neuron_id;
	logic [`AXON_CNT_W-1:0]   axon_id;
	logic [`DSIZE-1:0]        status_value;
	logic load_head;
	logic load_field;
	logic wr_status;
	logic wr_config;
	logic set_spike;
	logic tick;

	// vc bits sit between header and payload and are not used here
	assign flit_hdr = noc_pkg::flit_hdr_e'(flit_i[`FLIT_W-1 -: `HDR_W]);
	assign flit_payload = flit_i[`PAYLOAD_W-1:0];

	decoder_fsm decoder_fsm_i
	(
		.neuron_clk   (neuron_clk),
		.neuron_rst   (neuron_rst),
		.flit_valid_i (flit_valid_i),
		.flit_hdr_i   (flit_hdr),
		.pkt_type_i   (pkt_type),
		.flit_ready_o (flit_ready_o),
		.load_head_o  (load_head),
		.load_field_o (load_field),
		.wr_status_o  (wr_status),
		.wr_config_o  (wr_config),
		.set_spike_o  (set_spike)
	);

	packet_assembler packet_assembler_i
	(
		.neuron_clk     (neuron_clk),
		.neuron_rst     (neuron_rst),
		.payload_i      (flit_payload),
		.load_head_i    (load_head),
		.load_field_i   (load_field),
		.pkt_type_o     (pkt_type),
		.neuron_id_o    (neuron_id),
		.axon_id_o      (axon_id),
		.status_value_o (status_value),
		.config_word_o  (config_word)
	);

	neuron_state_mem neuron_state_mem_i
	(
		.neuron_clk     (neuron_clk),
		.neuron_rst     (neuron_rst),
		.wr_status_i    (wr_status),
		.wr_config_i    (wr_config),
		.pkt_type_i     (pkt_type),
		.neuron_id_i    (neuron_id),
		.status_value_i (status_value),
		.config_word_i  (config_word),
		.rd_neuron_i    (rd_neuron_i),
		.rd_sel_i       (rd_sel_i),
		.rd_data_o      (rd_data_o)
	);

	spike_buffer spike_buffer_i
	(
		.neuron_clk        (neuron_clk),
		.neuron_rst        (neuron_rst),
		.set_spike_i       (set_spike),
		.axon_id_i         (axon_id),
		.tick_i            (tick),
		.spike_vec_o       (spike_vec_o),
		.spike_vec_valid_o (spike_vec_valid_o)
	);

	timestep_timer timestep_timer_i
	(
		.neuron_clk (neuron_clk),
		.neuron_rst (neuron_rst),
		.tick_o     (tick)
	);

endmodule

//--- testbench/neuro_core_rx_sva.sv
`timescale 1ns/1ps

module neuro_core_rx_sva
(
	input logic               neuron_clk,
	input logic               neuron_rst,
	input logic               flit_valid_i,
	input noc_pkg::flit_hdr_e flit_hdr_i,
	input logic               flit_ready_i,
	input logic               wr_status_i,
	input logic               wr_config_i,
	input logic               set_spike_i,
	input logic               spike_vec_valid_i
);

	// only one action per packet
	assert property (@(posedge neuron_clk) disable iff (!neuron_rst)
		$onehot0({wr_status_i, wr_config_i, set_spike_i}))
		else $error("more than one write strobe in a cycle");

	// a strobe comes with ready low, right after a tail or single handshake
	assert property (@(posedge neuron_clk) disable iff (!neuron_rst)
		(wr_status_i | wr_config_i | set_spike_i) |->
			(!flit_ready_i && $past(flit_valid_i && flit_ready_i &&
			((flit_hdr_i == noc_pkg::HDR_TAIL) || (flit_hdr_i == noc_pkg::HDR_SINGLE)))))
		else $error("write strobe with ready high or without a preceding tail handshake");

	assert property (@(posedge neuron_clk) disable iff (!neuron_rst)
		spike_vec_valid_i |=> !spike_vec_valid_i)
		else $error("spike_vec_valid_o held longer than one cycle");

endmodule

bind neuro_core_rx neuro_core_rx_sva neuro_core_rx_sva_i
(
	.neuron_clk        (neuron_clk),
	.neuron_rst        (neuron_rst),
	.flit_valid_i      (flit_valid_i),
	.flit_hdr_i        (flit_hdr),
	.flit_ready_i      (flit_ready_o),
	.wr_status_i       (wr_status),
	.wr_config_i       (wr_config),
	.set_spike_i       (set_spike),
	.spike_vec_valid_i (spike_vec_valid_o)
);

//--- testbench/neuro_core_rx_tb.sv
`timescale 1ns/1ps
`include "neuro_cfg.svh"

module neuro_core_rx_tb;

	logic neuron_clk;
	logic neuron_rst;
	logic [`FLIT_W-1:0] flit_i;
	logic flit_valid_i;
	logic flit_ready_o;
	logic [`NEURON_CNT_W-1:0] rd_neuron_i;
	neuro_pkg::mem_sel_e rd_sel_i;
	logic [`RD_DATA_W-1:0] rd_data_o;
	logic [`AXON_CNT-1:0] spike_vec_o;
	logic spike_vec_valid_o;

	// packet list from the stim file
	logic [3:0] kind_a [64];
	logic [5:0] id_a [64];
	logic [15:0] val_a [64][3];
	logic [63:0] exp_a [64];
	int nf_a [64];
	int gap_a [64];
	int pkt_cnt;

	// reference model
	logic [15:0] exp_bias [`NEURON_CNT];
	logic [15:0] exp_thr [`NEURON_CNT];
	logic [15:0] exp_pot [`NEURON_CNT];
	logic [39:0] exp_cfg [`NEURON_CNT];
	logic [`AXON_CNT-1:0] exp_spikes;

	int cyc;
	int limit;
	int checks;
	int errors;
	int pulse_cnt;
	integer seed;

	neuro_core_rx neuro_core_rx_i
	(
		.neuron_clk        (neuron_clk),
		.neuron_rst        (neuron_rst),
		.flit_i            (flit_i),
		.flit_valid_i      (flit_valid_i),
		.flit_ready_o      (flit_ready_o),
		.rd_neuron_i       (rd_neuron_i),
		.rd_sel_i          (rd_sel_i),
		.rd_data_o         (rd_data_o),
		.spike_vec_o       (spike_vec_o),
		.spike_vec_valid_o (spike_vec_valid_o)
	);

	initial
	begin
		neuron_clk = 1'b0;
		forever #2 neuron_clk = ~neuron_clk;
	end

	always @(posedge neuron_clk)
	begin
		if (neuron_rst)
			cyc <= cyc + 1;
	end

	always @(negedge neuron_clk)
	begin
		if (limit > 0 && cyc > limit)
		begin
			$display("timeout: run went past %0d cycles", limit);
			$display("*** FAILED ***");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		begin
			checks++;
			assert (got === exp)
			else
			begin
				errors++;
				$display("[ERROR] %s got %h expected %h", name, got, exp);
			end
		end
	endtask

	// pulse in the first cycle of every timestep after the first
	// a pulse carries every spike written before its tick
	always @(negedge neuron_clk)
	begin
		if (neuron_rst)
		begin
			check_value("spike_vec_valid_o", 64'(spike_vec_valid_o),
				64'(cyc != 0 && (cyc % `TIMESTEP_CYCLES) == 0));
			if (spike_vec_valid_o)
			begin
				check_value("spike_vec_o", spike_vec_o, exp_spikes);
				exp_spikes = '0;
				pulse_cnt++;
			end
		end
	end

	function automatic neuro_pkg::mem_sel_e sel_for_kind(input logic [3:0] kind);
		case (kind)
			4'd1: return neuro_pkg::RD_BIAS;
			4'd2: return neuro_pkg::RD_THRESHOLD;
			4'd3: return neuro_pkg::RD_POTENTIAL;
			default: return neuro_pkg::RD_CONFIG;
		endcase
	endfunction

	function automatic logic [63:0] model_word(input int n, input int s);
		case (s)
			0: return {48'h0, exp_bias[n]};
			1: return {48'h0, exp_thr[n]};
			2: return {48'h0, exp_pot[n]};
			default: return {24'h0, exp_cfg[n]};
		endcase
	endfunction

	task automatic read_stim();
		int fd;
		int n;
		int t_n;
		int t_gap;
		logic [31:0] t_kind;
		logic [31:0] t_id;
		logic [31:0] t_v0;
		logic [31:0] t_v1;
		logic [31:0] t_v2;
		logic [63:0] t_exp;
		logic [8*128-1:0] line;
		begin
			pkt_cnt = 0;
			fd = $fopen("testbench/neuro_core_rx_stim.txt", "r");
			if (fd == 0)
			begin
				$display("cannot open the stim file");
				errors++;
			end
			else
			begin
				while (!$feof(fd) && pkt_cnt < 64)
				begin
					line = '0;
					n = $fgets(line, fd);
					n = $sscanf(line, "%h %h %d %h %h %h %d %h", t_kind, t_id, t_n,
						t_v0, t_v1, t_v2, t_gap, t_exp);
					if (n == 8)
					begin
						kind_a[pkt_cnt] = t_kind[3:0];
						id_a[pkt_cnt] = t_id[5:0];
						nf_a[pkt_cnt] = t_n;
						val_a[pkt_cnt][0] = t_v0[15:0];
						val_a[pkt_cnt][1] = t_v1[15:0];
						val_a[pkt_cnt][2] = t_v2[15:0];
						gap_a[pkt_cnt] = t_gap;
						exp_a[pkt_cnt] = t_exp;
						pkt_cnt++;
					end
				end
				$fclose(fd);
			end
		end
	endtask

	// valid may drop before a flit, and is held until the handshake
	task automatic present_flit(input logic [`FLIT_W-1:0] f, input bit spike);
		bit hs;
		begin
			hs = 1'b0;
			while (($random(seed) & 3) == 0)
			begin
				flit_valid_i <= 1'b0;
				@(posedge neuron_clk);
			end
			// keep the spike handshake out of the last cycles of a timestep
			while (spike && ((cyc + 1) % `TIMESTEP_CYCLES) >= `TIMESTEP_CYCLES - 3)
			begin
				flit_valid_i <= 1'b0;
				@(posedge neuron_clk);
			end
			flit_i <= f;
			flit_valid_i <= 1'b1;
			while (!hs)
			begin
				@(negedge neuron_clk);
				hs = flit_ready_o;
				@(posedge neuron_clk);
			end
		end
	endtask

	task automatic send_packet(input int p);
		logic [1:0] hdr;
		logic [31:0] payload;
		logic [39:0] cfg;
		int n;
		int k;
		begin
			n = nf_a[p];
			cfg = '0;
			for (k = 0; k < n; k++)
			begin
				if (n == 1)
					hdr = noc_pkg::HDR_SINGLE;
				else if (k == 0)
					hdr = noc_pkg::HDR_HEAD;
				else if (k == n - 1)
					hdr = noc_pkg::HDR_TAIL;
				else
					hdr = noc_pkg::HDR_BODY;
				if (kind_a[p] == 4'd0)
					payload = {kind_a[p], 10'h0, id_a[p], 12'h0};
				else
					payload = {kind_a[p], 2'b0, id_a[p], 2'(k), 2'b0, val_a[p][k]};
				present_flit({hdr, 4'(p), payload}, kind_a[p] == 4'd0);
				if (k == 0)
					cfg[39:24] = val_a[p][k];
				else if (k == 1)
					cfg[23:8] = val_a[p][k];
				else
					cfg[7:0] = val_a[p][k][7:0];
			end
			flit_valid_i <= 1'b0;
			rd_neuron_i <= id_a[p];
			rd_sel_i <= sel_for_kind(kind_a[p]);
			case (kind_a[p])
				4'd1: exp_bias[id_a[p]] = val_a[p][n-1];
				4'd2: exp_thr[id_a[p]] = val_a[p][n-1];
				4'd3: exp_pot[id_a[p]] = val_a[p][n-1];
				4'd6: exp_cfg[id_a[p]] = cfg;
				default: exp_spikes[id_a[p]] = 1'b1;
			endcase
			@(negedge neuron_clk);
			check_value("flit_ready_o in write", 64'(flit_ready_o), 64'h0);
			@(negedge neuron_clk);
			check_value("flit_ready_o after write", 64'(flit_ready_o), 64'h1);
			if (kind_a[p] != 4'd0)
				check_value("rd_data_o", 64'(rd_data_o), exp_a[p]);
			@(posedge neuron_clk);
			repeat (gap_a[p]) @(posedge neuron_clk);
		end
	endtask

	initial
	begin
		int p;
		int n;
		int s;
		int start;
		seed = 32'h58d1;
		neuron_rst = 1'b0;
		flit_i = '0;
		flit_valid_i = 1'b0;
		rd_neuron_i = '0;
		rd_sel_i = neuro_pkg::RD_BIAS;
		exp_bias = '{default: '0};
		exp_thr = '{default: '0};
		exp_pot = '{default: '0};
		exp_cfg = '{default: '0};
		exp_spikes = '0;
		cyc = 0;
		limit = 0;
		checks = 0;
		errors = 0;
		pulse_cnt = 0;
		read_stim();
		// flits and gaps, four timesteps, and the closing sweep
		limit = 4 * `TIMESTEP_CYCLES + 4 * `NEURON_CNT;
		for (p = 0; p < pkt_cnt; p++)
			limit += nf_a[p] + gap_a[p];
		repeat (8) @(posedge neuron_clk);
		neuron_rst <= 1'b1;
		@(posedge neuron_clk);
		for (p = 0; p < pkt_cnt; p++)
			send_packet(p);
		// let the last spikes come out
		start = pulse_cnt;
		while (pulse_cnt == start)
			@(posedge neuron_clk);
		for (n = 0; n < `NEURON_CNT; n++)
		begin
			for (s = 0; s < 4; s++)
			begin
				@(posedge neuron_clk);
				rd_neuron_i <= n[5:0];
				rd_sel_i <= neuro_pkg::mem_sel_e'(s[1:0]);
				@(negedge neuron_clk);
				check_value("rd_data_o sweep", 64'(rd_data_o), model_word(n, s));
			end
		end
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- testbench/neuro_core_rx_stim.txt
# kind id flits v0 v1 v2 gap expected  (flits and gap decimal, rest hex)
# kind 0 spike (id is axon), 1 bias, 2 threshold, 3 potential, 6 config-A
1 05 1 1a2b 0 0 2 1a2b
2 05 1 7fff 0 0 1 7fff
3 05 1 0123 0 0 0 0123
0 03 1 0 0 0 1 0
0 3f 1 0 0 0 0 0
1 06 3 1111 2222 3333 2 3333
2 06 2 aaaa bbbb 0 1 bbbb
3 2a 3 dead beef cafe 0 cafe
1 05 2 0001 ffff 0 3 ffff
6 07 3 1234 abcd 015a 2 1234abcd5a
6 08 1 4321 0 0 1 4321000000
6 09 2 0f0f f0f0 0 0 0f0ff0f000
0 00 1 0 0 0 0 0
0 10 1 0 0 0 30 0
0 03 1 0 0 0 2 0
0 21 1 0 0 0 1 0
1 3f 1 8001 0 0 0 8001
2 00 3 0002 0003 0004 1 0004
6 3f 3 ffff 0000 00ff 2 ffff0000ff
3 11 2 5555 6666 0 40 6666
0 3f 1 0 0 0 0 0
0 20 1 0 0 0 1 0
6 07 2 0042 0043 0 0 0042004300

//--- neuro_core_rx.f
+incdir+logic
logic/noc_pkg.sv
logic/neuro_pkg.sv
logic/decoder_fsm.sv
logic/packet_assembler.sv
logic/spike_buffer.sv
logic/timestep_timer.sv
logic/neuron_state_mem.sv
logic/neuro_core_rx.sv
testbench/neuro_core_rx_sva.sv
testbench/neuro_core_rx_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= neuro_core_rx_tb
FILELIST ?= neuro_core_rx.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS ?= --lint-only --timing --timescale 1ns/1ps
PASS_MSG ?= *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
